// ==== hdl/vproc_settings.svh ====
//##########################################################################
// Vector write-back settings
// Register geometry, pipeline count and the pipeline to port/unit map
//##########################################################################

`ifndef VPROC_SETTINGS_SVH
`define VPROC_SETTINGS_SVH

// Register geometry
`define VPROC_VREG_W        64
`define VPROC_VREG_BE_W     (`VPROC_VREG_W / 8)
`define VPROC_VADDR_W       5
`define VPROC_VREG_CNT      (1 << `VPROC_VADDR_W)

// Pipelines and register file write ports
`define VPROC_PIPE_CNT      3
`define VPROC_VPORT_WR_CNT  2

// Pipelines 1 and 2 share write port 1
`define VPROC_PIPE0_PORT    0
`define VPROC_PIPE1_PORT    1
`define VPROC_PIPE2_PORT    1

`define VPROC_PIPE0_UNIT    UNIT_ALU   // Names of vproc_pkg::unit_e
`define VPROC_PIPE1_UNIT    UNIT_MUL
`define VPROC_PIPE2_UNIT    UNIT_ELEM

`endif

// ==== hdl/vproc_pkg.sv ====
//##########################################################################
// Vector write-back types
// Unit kinds, write request, register file port and issue event
//##########################################################################

`default_nettype none

`include "vproc_settings.svh"

package vproc_pkg;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_ELEM,
        UNIT_LSU
    } unit_e;

    // Write request from one execution pipeline
    typedef struct packed {
        logic                        valid;
        logic [`VPROC_VADDR_W-1:0]   addr;
        logic [`VPROC_VREG_BE_W-1:0] be;
        logic [`VPROC_VREG_W-1:0]    data;
        logic                        clr;      // Retires a pending hazard
        logic [1:0]                  clr_cnt;  // Log2 of bulk clear group size
    } vreg_wr_t;

    typedef struct packed {
        logic                        en;
        logic [`VPROC_VADDR_W-1:0]   addr;
        logic [`VPROC_VREG_BE_W-1:0] be;
        logic [`VPROC_VREG_W-1:0]    data;
    } vrf_wr_t;

    typedef struct packed {
        logic                      valid;
        logic [`VPROC_VADDR_W-1:0] addr;
        logic [1:0]                cnt;
    } vreg_issue_t;

    // Aligned group of 2**cnt registers containing addr
    function automatic logic [`VPROC_VREG_CNT-1:0] group_mask(
        input logic [`VPROC_VADDR_W-1:0] addr,
        input logic [1:0]                cnt
    );
        logic [`VPROC_VADDR_W-1:0] sel;
        logic [`VPROC_VADDR_W-1:0] idx;
        group_mask = '0;
        sel        = {`VPROC_VADDR_W{1'b1}} << cnt;
        for (int j = 0; j < `VPROC_VREG_CNT; j++) begin
            idx           = j[`VPROC_VADDR_W-1:0];
            group_mask[j] = ((idx & sel) == (addr & sel));
        end
    endfunction

endpackage

`default_nettype wire

// ==== hdl/vreg_wr_mux.sv ====
//##########################################################################
// Vector register write multiplexer
// Arbitrates pipeline writes onto the register file write ports and
// registers the mask of pending writes to clear
//##########################################################################

`default_nettype none
`timescale 1ns/1ns

`include "vproc_settings.svh"

module vreg_wr_mux import vproc_pkg::*; (
    input  logic                                  clk_i,
    input  logic                                  reset_i,

    input  vreg_wr_t [`VPROC_PIPE_CNT-1:0]        pipe_wr_i,
    output logic     [`VPROC_PIPE_CNT-1:0]        pipe_wr_ready_o,

    output vrf_wr_t  [`VPROC_VPORT_WR_CNT-1:0]    vrf_wr_o,

    output logic     [`VPROC_VREG_CNT-1:0]        pend_clr_o
);

    localparam int PIPE_PORT [`VPROC_PIPE_CNT] = '{
        `VPROC_PIPE0_PORT,
        `VPROC_PIPE1_PORT,
        `VPROC_PIPE2_PORT
    };

    localparam unit_e PIPE_UNIT [`VPROC_PIPE_CNT] = '{
        `VPROC_PIPE0_UNIT,
        `VPROC_PIPE1_UNIT,
        `VPROC_PIPE2_UNIT
    };

    logic [`VPROC_PIPE_CNT-1:0]                      pipe_taken;
    logic [`VPROC_PIPE_CNT-1:0]                      sharer_valid;
    logic [`VPROC_PIPE_CNT-1:0][`VPROC_VREG_CNT-1:0] pipe_clr_mask;
    logic [`VPROC_VREG_CNT-1:0]                      pend_clr_d;
    logic [`VPROC_VREG_CNT-1:0]                      pend_clr_q;

    //##########################################################################
    // Port arbitration, lowest pipeline index wins

    always_comb begin
        logic found;
        pipe_wr_ready_o = '1;
        for (int p = 0; p < `VPROC_VPORT_WR_CNT; p++) begin
            vrf_wr_o[p] = '0;
            found       = 1'b0;
            for (int j = 0; j < `VPROC_PIPE_CNT; j++) begin
                if (!found && (PIPE_PORT[j] == p) && pipe_wr_i[j].valid) begin
                    found            = 1'b1;
                    vrf_wr_o[p].en   = 1'b1;
                    vrf_wr_o[p].addr = pipe_wr_i[j].addr;
                    vrf_wr_o[p].be   = pipe_wr_i[j].be;
                    vrf_wr_o[p].data = pipe_wr_i[j].data;
                    // Hold off later pipelines on this port
                    for (int k = j + 1; k < `VPROC_PIPE_CNT; k++) begin
                        if (PIPE_PORT[k] == p) begin
                            pipe_wr_ready_o[k] = 1'b0;
                        end
                    end
                end
            end
        end
    end

    // Any valid lower-index pipeline on the same port
    always_comb begin
        sharer_valid = '0;
        for (int k = 0; k < `VPROC_PIPE_CNT; k++) begin
            for (int j = 0; j < k; j++) begin
                if ((PIPE_PORT[j] == PIPE_PORT[k]) && pipe_wr_i[j].valid) begin
                    sharer_valid[k] = 1'b1;
                end
            end
        end
    end

    //##########################################################################
    // Pending-write clear masks

    for (genvar i = 0; i < `VPROC_PIPE_CNT; i++) begin : g_pipe
        localparam bit BULK_CLR = (PIPE_UNIT[i] == UNIT_ELEM);

        logic [1:0] clr_cnt;

        assign pipe_taken[i] = pipe_wr_i[i].valid & pipe_wr_ready_o[i];
        assign clr_cnt       = BULK_CLR ? pipe_wr_i[i].clr_cnt : 2'd0;  // Single register

        assign pipe_clr_mask[i] = (pipe_taken[i] && pipe_wr_i[i].clr) ?
                                  group_mask(pipe_wr_i[i].addr, clr_cnt) : '0;

        // A stalled pipeline always has a valid sharer ahead of it
        assert property (@(posedge clk_i) disable iff (reset_i)
            !pipe_wr_ready_o[i] |-> sharer_valid[i]);

        // Only the permute pipeline may request bulk clears
        assert property (@(posedge clk_i) disable iff (reset_i)
            pipe_wr_i[i].valid |-> (BULK_CLR || (pipe_wr_i[i].clr_cnt == 2'd0)));
    end

    always_comb begin
        pend_clr_d = '0;
        for (int i = 0; i < `VPROC_PIPE_CNT; i++) begin
            pend_clr_d = pend_clr_d | pipe_clr_mask[i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pend_clr_q <= '0;
        end else begin
            pend_clr_q <= pend_clr_d;
        end
    end

    assign pend_clr_o = pend_clr_q;  // One cycle after the write edge

endmodule

`default_nettype wire

// ==== hdl/vreg_file.sv ====
//##########################################################################
// Vector register file
// 32 entries, two byte-masked write ports and one registered read port
//##########################################################################

`default_nettype none
`timescale 1ns/1ns

`include "vproc_settings.svh"

module vreg_file import vproc_pkg::*; (
    input  logic                                  clk_i,
    input  logic                                  reset_i,

    input  vrf_wr_t [`VPROC_VPORT_WR_CNT-1:0]     wr_i,

    input  logic    [`VPROC_VADDR_W-1:0]          rd_addr_i,
    output logic    [`VPROC_VREG_W-1:0]           rd_data_o
);

    logic [`VPROC_VREG_W-1:0]       regs [`VPROC_VREG_CNT];
    logic [`VPROC_VADDR_W-1:0]      rd_addr_q;
    logic [`VPROC_VPORT_WR_CNT-1:0] wr_en;

    //##########################################################################
    // Write ports

    // Ports are applied in order, so the higher port wins on a shared byte
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int r = 0; r < `VPROC_VREG_CNT; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int p = 0; p < `VPROC_VPORT_WR_CNT; p++) begin
                if (wr_i[p].en) begin
                    for (int b = 0; b < `VPROC_VREG_BE_W; b++) begin
                        if (wr_i[p].be[b]) begin
                            regs[wr_i[p].addr][b*8 +: 8] <= wr_i[p].data[b*8 +: 8];
                        end
                    end
                end
            end
        end
    end

    //##########################################################################
    // Read port

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rd_addr_q <= '0;
        end else begin
            rd_addr_q <= rd_addr_i;
        end
    end

    assign rd_data_o = regs[rd_addr_q];  // Includes writes of the capture edge

    always_comb begin
        for (int p = 0; p < `VPROC_VPORT_WR_CNT; p++) begin
            wr_en[p] = wr_i[p].en;
        end
    end

    assert property (@(posedge clk_i) disable iff (reset_i) !$isunknown(wr_en));

endmodule

`default_nettype wire

// ==== hdl/vreg_hazard_tracker.sv ====
//##########################################################################
// Vector register hazard tracker
// Pending-write bit per register, set on issue and cleared on write-back
//##########################################################################

`default_nettype none
`timescale 1ns/1ns

`include "vproc_settings.svh"

module vreg_hazard_tracker import vproc_pkg::*; (
    input  logic                          clk_i,
    input  logic                          reset_i,

    input  vreg_issue_t                   issue_i,
    input  logic [`VPROC_VREG_CNT-1:0]    clr_i,

    output logic [`VPROC_VREG_CNT-1:0]    pend_o
);

    logic [`VPROC_VREG_CNT-1:0] issue_mask;
    logic [`VPROC_VREG_CNT-1:0] pend_d;
    logic [`VPROC_VREG_CNT-1:0] pend_q;

    //##########################################################################
    // Next pending state

    // Issue selects an aligned group of 2**cnt registers
    assign issue_mask = issue_i.valid ? group_mask(issue_i.addr, issue_i.cnt) : '0;

    always_comb begin
        pend_d = pend_q;
        pend_d = pend_d & ~clr_i;
        pend_d = pend_d | issue_mask;  // Newer instruction wins over a write-back
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pend_q <= '0;
        end else begin
            pend_q <= pend_d;
        end
    end

    assign pend_o = pend_q;

    //##########################################################################
    // Checks

    // A write-back clear must match a pending register
    assert property (@(posedge clk_i) disable iff (reset_i)
        (clr_i & ~pend_q) == '0);

endmodule

`default_nettype wire

// ==== hdl/vproc_wb_top.sv ====
//##########################################################################
// Vector write-back top level
// Write multiplexer, register file and hazard tracker
//##########################################################################

`default_nettype none
`timescale 1ns/1ns

`include "vproc_settings.svh"

module vproc_wb_top import vproc_pkg::*; (
    input  logic                                  clk_i,
    input  logic                                  reset_i,

    // Pipeline write-back
    input  vreg_wr_t [`VPROC_PIPE_CNT-1:0]        wr_i,
    output logic     [`VPROC_PIPE_CNT-1:0]        wr_ready_o,

    // Issue and hazard state
    input  vreg_issue_t                           issue_i,
    output logic     [`VPROC_VREG_CNT-1:0]        pend_o,

    // Observation read port
    input  logic     [`VPROC_VADDR_W-1:0]         rd_addr_i,
    output logic     [`VPROC_VREG_W-1:0]          rd_data_o
);

    vrf_wr_t [`VPROC_VPORT_WR_CNT-1:0] vrf_wr;
    logic    [`VPROC_VREG_CNT-1:0]     pend_clr;

    vreg_wr_mux u_wr_mux (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .pipe_wr_i       (wr_i),
        .pipe_wr_ready_o (wr_ready_o),
        .vrf_wr_o        (vrf_wr),
        .pend_clr_o      (pend_clr)
    );

    vreg_file u_vrf (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .wr_i      (vrf_wr),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o)
    );

    vreg_hazard_tracker u_hazard (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .issue_i (issue_i),
        .clr_i   (pend_clr),
        .pend_o  (pend_o)
    );

endmodule

`default_nettype wire

// ==== test/tb_vproc_wb.sv ====
//##########################################################################
// Vector write-back testbench
// Drives the pipeline, issue and read ports and checks against a shadow model
//##########################################################################

`default_nettype none
`timescale 1ns/1ns

`include "vproc_settings.svh"

module tb_vproc_wb import vproc_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int WR_PAIRS     = 8;
    localparam int HOLD_CYCLES  = 4;
    localparam int RAND_CYCLES  = 200;
    localparam int HS_LIMIT     = 16;   // Cycles a request may wait for ready
    localparam int TEST_CYCLES  = RESET_CYCLES + 34 + 2 * WR_PAIRS + HOLD_CYCLES
                                  + HS_LIMIT + RAND_CYCLES + 40;
    localparam int MARGIN       = 200;

    logic                                clk_i;
    logic                                reset_i;
    vreg_wr_t [`VPROC_PIPE_CNT-1:0]      wr_i;
    logic     [`VPROC_PIPE_CNT-1:0]      wr_ready_o;
    vreg_issue_t                         issue_i;
    logic     [`VPROC_VREG_CNT-1:0]      pend_o;
    logic     [`VPROC_VADDR_W-1:0]       rd_addr_i;
    logic     [`VPROC_VREG_W-1:0]        rd_data_o;

    // Shadow model
    logic [`VPROC_VREG_W-1:0]   m_regs [`VPROC_VREG_CNT];
    logic [`VPROC_VREG_CNT-1:0] m_pend;
    logic [`VPROC_VREG_CNT-1:0] m_clr_q;   // Clear mask one edge behind the write
    logic [`VPROC_VADDR_W-1:0]  m_rd_addr;

    logic [31:0] lfsr_state;
    string       test_name;
    int          err_cnt;
    int          test_err_start;
    int          pass_cnt;
    int          fail_cnt;

    vproc_wb_top u_dut (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .wr_i       (wr_i),
        .wr_ready_o (wr_ready_o),
        .issue_i    (issue_i),
        .pend_o     (pend_o),
        .rd_addr_i  (rd_addr_i),
        .rd_data_o  (rd_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    //##########################################################################
    // Reference functions

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        rand_bits = '0;
        for (int i = 0; i < n; i++) begin
            rand_bits[i] = lfsr_state[0];
            lfsr_state   = lfsr_next(lfsr_state);
        end
    endfunction

    // Aligned group of 2**cnt registers around addr
    function automatic logic [`VPROC_VREG_CNT-1:0] group_ref(
        input logic [`VPROC_VADDR_W-1:0] addr,
        input logic [1:0]                cnt
    );
        int base;
        int size;
        group_ref = '0;
        size      = 1 << cnt;
        base      = (int'(addr) >> cnt) << cnt;
        for (int i = 0; i < size; i++) begin
            group_ref[base + i] = 1'b1;
        end
    endfunction

    function automatic logic [63:0] merge_bytes(
        input logic [63:0] old_val,
        input logic [63:0] new_val,
        input logic [7:0]  be
    );
        merge_bytes = old_val;
        for (int b = 0; b < 8; b++) begin
            if (be[b]) begin
                merge_bytes[b*8 +: 8] = new_val[b*8 +: 8];
            end
        end
    endfunction

    // Pipeline 2 shares port 1 with pipeline 1
    function automatic logic [2:0] ready_ref(input vreg_wr_t [2:0] wr);
        ready_ref    = 3'b111;
        ready_ref[2] = !wr[1].valid;
    endfunction

    function automatic vreg_wr_t rand_req();
        vreg_wr_t w;
        w       = '0;
        w.valid = 1'(rand_bits(1));
        w.addr  = `VPROC_VADDR_W'(rand_bits(`VPROC_VADDR_W));
        w.be    = `VPROC_VREG_BE_W'(rand_bits(`VPROC_VREG_BE_W));
        w.data  = rand_bits(`VPROC_VREG_W);
        return w;
    endfunction

    function automatic vreg_issue_t make_issue(input logic [4:0] addr, input logic [1:0] cnt);
        vreg_issue_t iss;
        iss.valid = 1'b1;
        iss.addr  = addr;
        iss.cnt   = cnt;
        return iss;
    endfunction

    //##########################################################################
    // Model and comparison

    always @(posedge clk_i) begin
        logic [2:0] rdy;
        if (reset_i) begin
            for (int r = 0; r < `VPROC_VREG_CNT; r++) begin
                m_regs[r] = '0;
            end
            m_pend    = '0;
            m_clr_q   = '0;
            m_rd_addr = '0;
        end else begin
            rdy     = ready_ref(wr_i);
            m_pend  = (m_pend & ~m_clr_q) |
                      (issue_i.valid ? group_ref(issue_i.addr, issue_i.cnt) : '0);
            m_clr_q = '0;
            for (int j = 0; j < `VPROC_PIPE_CNT; j++) begin
                if (wr_i[j].valid && rdy[j]) begin
                    m_regs[wr_i[j].addr] = merge_bytes(m_regs[wr_i[j].addr],
                                                       wr_i[j].data, wr_i[j].be);
                    if (wr_i[j].clr) begin   // Only the ELEM pipeline clears in bulk
                        m_clr_q = m_clr_q | group_ref(wr_i[j].addr,
                                                      (j == 2) ? wr_i[j].clr_cnt : 2'd0);
                    end
                end
            end
            m_rd_addr = rd_addr_i;
        end
    end

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, exp, act);
            err_cnt++;
        end
    endtask

    always @(negedge clk_i) begin
        if (!reset_i) begin
            check_value("rd_data_o", m_regs[m_rd_addr], rd_data_o);
            check_value("pend_o", 64'(m_pend), 64'(pend_o));
            check_value("wr_ready_o", 64'(ready_ref(wr_i)), 64'(wr_ready_o));
        end
    end

    initial begin
        #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
        $display("Simulation timed out after %0d cycles", TEST_CYCLES + MARGIN);
        $display("TESTS FAILED");
        $finish;
    end

    //##########################################################################
    // Stimulus helpers

    task automatic step();
        @(posedge clk_i);
        #2;
    endtask

    task automatic start_test(input string name);
        test_name      = name;
        test_err_start = err_cnt;
    endtask

    task automatic finish_test();
        if (err_cnt == test_err_start) begin
            pass_cnt++;
            $display("Test %s: ok", test_name);
        end else begin
            fail_cnt++;
            $display("Test %s: %0d error(s)", test_name, err_cnt - test_err_start);
        end
    endtask

    // Holds the request until the handshake edge, then drops valid
    task automatic wait_taken(input int pipe);
        int n;
        n = 0;
        @(negedge clk_i);
        while (!wr_ready_o[pipe] && n < HS_LIMIT) begin
            @(negedge clk_i);
            n++;
        end
        if (!wr_ready_o[pipe]) begin
            $display("Test %s: write from pipeline %0d was never accepted", test_name, pipe);
            err_cnt++;
        end
        step();
        wr_i[pipe].valid = 1'b0;
    endtask

    //##########################################################################
    // Tests

    initial begin
        logic [2:0]                rdy;
        logic [`VPROC_VADDR_W-1:0] rd_next;
        lfsr_state = 32'h6b68_e557;
        err_cnt    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        wr_i       = '0;
        issue_i    = '0;
        rd_addr_i  = '0;
        reset_i    = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #2 reset_i = 1'b0;

        start_test("reset");
        for (int r = 0; r < `VPROC_VREG_CNT; r++) begin
            rd_addr_i = r[`VPROC_VADDR_W-1:0];
            step();
        end
        check_value("pend_o", 64'd0, 64'(pend_o));
        finish_test();

        start_test("dual_write");
        for (int i = 0; i < WR_PAIRS; i++) begin
            wr_i[0]       = rand_req();
            wr_i[1]       = rand_req();
            wr_i[0].valid = 1'b1;
            wr_i[1].valid = 1'b1;
            rd_addr_i     = wr_i[0].addr;
            rd_next       = wr_i[1].addr;
            step();
            wr_i      = '0;
            rd_addr_i = rd_next;
            step();
        end
        finish_test();

        start_test("contention");
        wr_i[1]       = rand_req();
        wr_i[1].valid = 1'b1;
        wr_i[2]       = rand_req();
        wr_i[2].valid = 1'b1;
        rd_addr_i     = wr_i[2].addr;
        repeat (HOLD_CYCLES) begin
            @(negedge clk_i);
            check_value("wr_ready_o[2]", 64'd0, 64'(wr_ready_o[2]));
            step();
        end
        wr_i[1].valid = 1'b0;   // Port 1 freed for pipeline 2
        wait_taken(2);
        step();
        for (int c = 0; c < RAND_CYCLES; c++) begin
            wr_i[0] = rand_req();
            wr_i[1] = rand_req();
            if (!wr_i[2].valid) begin
                wr_i[2] = rand_req();
            end
            rd_addr_i = `VPROC_VADDR_W'(rand_bits(`VPROC_VADDR_W));
            @(negedge clk_i);
            rdy = wr_ready_o;
            step();
            if (wr_i[2].valid && rdy[2]) begin
                wr_i[2].valid = 1'b0;
            end
        end
        wr_i = '0;
        step();
        finish_test();

        start_test("single_clear");
        issue_i = make_issue(5'd5, 2'd0);
        step();
        issue_i = make_issue(5'd9, 2'd0);
        step();
        issue_i = '0;
        check_value("pend_o[5]", 64'd1, 64'(pend_o[5]));
        wr_i[0]       = rand_req();
        wr_i[0].valid = 1'b1;
        wr_i[0].addr  = 5'd5;
        wr_i[0].clr   = 1'b1;
        rd_addr_i     = 5'd5;
        wait_taken(0);
        check_value("pend_o[5]", 64'd1, 64'(pend_o[5]));
        step();
        check_value("pend_o[5]", 64'd0, 64'(pend_o[5]));
        check_value("pend_o[9]", 64'd1, 64'(pend_o[9]));
        finish_test();

        start_test("bulk_clear");
        issue_i = make_issue(5'd16, 2'd2);
        step();
        issue_i = '0;
        check_value("pend_o group", 64'(group_ref(5'd18, 2'd2)),
                    64'(pend_o & group_ref(5'd18, 2'd2)));
        wr_i[2]         = rand_req();
        wr_i[2].valid   = 1'b1;
        wr_i[2].addr    = 5'd18;
        wr_i[2].clr     = 1'b1;
        wr_i[2].clr_cnt = 2'd2;
        rd_addr_i       = 5'd18;
        wait_taken(2);
        step();
        check_value("pend_o group", 64'd0, 64'(pend_o & group_ref(5'd18, 2'd2)));
        finish_test();

        start_test("set_meets_clear");
        issue_i = make_issue(5'd12, 2'd0);
        step();
        issue_i       = '0;
        wr_i[0]       = rand_req();
        wr_i[0].valid = 1'b1;
        wr_i[0].addr  = 5'd12;
        wr_i[0].clr   = 1'b1;
        wait_taken(0);
        issue_i = make_issue(5'd12, 2'd0);   // Lands on the clearing edge
        step();
        issue_i = '0;
        check_value("pend_o[12]", 64'd1, 64'(pend_o[12]));
        step();
        check_value("pend_o[12]", 64'd1, 64'(pend_o[12]));
        finish_test();

        $display("Tests run: %0d, ok: %0d, with errors: %0d, error lines: %0d",
                 pass_cnt + fail_cnt, pass_cnt, fail_cnt, err_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hdl
hdl/vproc_pkg.sv
hdl/vreg_wr_mux.sv
hdl/vreg_file.sv
hdl/vreg_hazard_tracker.sv
hdl/vproc_wb_top.sv
test/tb_vproc_wb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the vector write-back testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_vproc_wb \
    -f filelist.f -o sim_tb > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -qx "TESTS PASSED" sim.log \
    && echo "Simulation finished without errors" \
    || { echo "Simulation reported errors"; exit 1; }
